// File: source/bus_pkg.sv
package bus_pkg;

	//======================================================================
	// Bus geometry

	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;

	// Command queue depth, also the initial credit count
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_ADDR_WIDTH = $clog2(QUEUE_DEPTH);
	localparam int CREDIT_WIDTH = 3;

	// On-chip RAM, word index taken from address bits 9 to 2
	localparam int RAM_WORDS = 256;
	localparam int RAM_INDEX_WIDTH = $clog2(RAM_WORDS);

	localparam int LED_WIDTH = 10;

	//======================================================================
	// DMA register map, index is address bits 3 to 2

	localparam logic [1:0] DMA_REG_SOURCE = 2'd0;
	localparam logic [1:0] DMA_REG_DEST = 2'd1;
	localparam logic [1:0] DMA_REG_COUNT = 2'd2;
	localparam logic [1:0] DMA_REG_CONTROL = 2'd3;

	//======================================================================
	// Enumerations

	typedef enum logic {
		CMD_READ = 1'b0,
		CMD_WRITE = 1'b1
	} cmd_op_t;

	// Top four address bits
	typedef enum logic [3:0] {
		REGION_RAM = 4'h1,
		REGION_LED = 4'h4,
		REGION_DMA = 4'h9
	} region_t;

	typedef enum logic [2:0] {
		MASTER_IDLE,
		MASTER_HOST_READ,
		DMA_ISSUE_READ,
		DMA_WAIT_READ,
		DMA_ISSUE_WRITE
	} master_state_t;

endpackage

// File: source/bus_master.sv
`timescale 1ns/10ps

module bus_master (
	input  logic                            clock,
	input  logic                            i_rst_n,

	// Host port
	input  logic                            i_host_request,
	input  logic                            i_host_rw,
	input  logic [bus_pkg::ADDR_WIDTH-1:0]  i_host_address,
	input  logic [bus_pkg::DATA_WIDTH-1:0]  i_host_wdata,
	output logic [bus_pkg::DATA_WIDTH-1:0]  o_host_rdata,
	output logic                            o_host_ready,

	// Command path towards the queue
	input  logic                            i_credit_return,
	output logic                            o_cmd_push,
	output bus_pkg::cmd_op_t                o_cmd_op,
	output logic [bus_pkg::ADDR_WIDTH-1:0]  o_cmd_address,
	output logic [bus_pkg::DATA_WIDTH-1:0]  o_cmd_wdata,

	// Read responses from the target
	input  logic                            i_rsp_valid,
	input  logic [bus_pkg::DATA_WIDTH-1:0]  i_rsp_rdata,

	output logic                            o_dma_busy
);

	bus_pkg::master_state_t state;
	logic [bus_pkg::CREDIT_WIDTH-1:0] credits;
	logic has_credit;

	// DMA programming registers
	logic [bus_pkg::ADDR_WIDTH-1:0] dma_source;
	logic [bus_pkg::ADDR_WIDTH-1:0] dma_dest;
	logic [bus_pkg::DATA_WIDTH-1:0] dma_count;

	// Working copies while a copy runs
	logic [bus_pkg::ADDR_WIDTH-1:0] src_ptr;
	logic [bus_pkg::ADDR_WIDTH-1:0] dst_ptr;
	logic [bus_pkg::DATA_WIDTH-1:0] remaining;
	logic [bus_pkg::DATA_WIDTH-1:0] dma_data;

	logic host_is_dma;
	logic [1:0] host_reg_index;
	logic dma_access;
	logic dma_start;
	logic host_issue;
	logic dma_ready_q;
	logic [bus_pkg::DATA_WIDTH-1:0] dma_rdata_q;

	//======================================================================
	// Host decode, only the DMA region is tested here

	assign host_is_dma = bus_pkg::region_t'(i_host_address[31:28]) == bus_pkg::REGION_DMA;
	assign host_reg_index = i_host_address[3:2];
	assign has_credit = credits != '0;

	// Register access, ready follows one cycle later
	assign dma_access = i_host_request && host_is_dma && !dma_ready_q;
	assign dma_start = dma_access && i_host_rw && host_reg_index == bus_pkg::DMA_REG_CONTROL
		&& i_host_wdata[0] && dma_count != '0 && !o_dma_busy;

	assign host_issue = state == bus_pkg::MASTER_IDLE && i_host_request && !host_is_dma
		&& has_credit;

	assign o_dma_busy = state == bus_pkg::DMA_ISSUE_READ || state == bus_pkg::DMA_WAIT_READ
		|| state == bus_pkg::DMA_ISSUE_WRITE;

	assign o_host_ready = dma_ready_q || (host_issue && i_host_rw)
		|| (state == bus_pkg::MASTER_HOST_READ && i_rsp_valid);
	assign o_host_rdata = dma_ready_q ? dma_rdata_q : i_rsp_rdata;

	//======================================================================
	// DMA register file

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			dma_ready_q <= 1'b0;
			dma_source <= '0;
			dma_dest <= '0;
			dma_count <= '0;
		end
		else
		begin
			dma_ready_q <= dma_access;
			if (dma_access && i_host_rw)
			begin
				case (host_reg_index)
					bus_pkg::DMA_REG_SOURCE: dma_source <= i_host_wdata;
					bus_pkg::DMA_REG_DEST: dma_dest <= i_host_wdata;
					bus_pkg::DMA_REG_COUNT: dma_count <= i_host_wdata;
					default: ;
				endcase
			end
		end
	end

	// Readback, CONTROL shows busy in bit 0
	always_ff @(posedge clock)
	begin
		if (dma_access)
		begin
			case (host_reg_index)
				bus_pkg::DMA_REG_SOURCE: dma_rdata_q <= dma_source;
				bus_pkg::DMA_REG_DEST: dma_rdata_q <= dma_dest;
				bus_pkg::DMA_REG_COUNT: dma_rdata_q <= dma_count;
				default: dma_rdata_q <= {{(bus_pkg::DATA_WIDTH-1){1'b0}}, o_dma_busy};
			endcase
		end
	end

	//======================================================================
	// Command generation

	always_comb
	begin
		o_cmd_push = 1'b0;
		o_cmd_op = bus_pkg::CMD_READ;
		o_cmd_address = i_host_address;
		o_cmd_wdata = i_host_wdata;
		case (state)
			bus_pkg::MASTER_IDLE:
			begin
				o_cmd_push = host_issue;
				if (i_host_rw)
					o_cmd_op = bus_pkg::CMD_WRITE;
			end
			bus_pkg::DMA_ISSUE_READ:
			begin
				o_cmd_push = has_credit;
				o_cmd_address = src_ptr;
			end
			bus_pkg::DMA_ISSUE_WRITE:
			begin
				o_cmd_push = has_credit;
				o_cmd_op = bus_pkg::CMD_WRITE;
				o_cmd_address = dst_ptr;
				o_cmd_wdata = dma_data;
			end
			default:
				o_cmd_push = 1'b0;
		endcase
	end

	// Credit counter, push and return may coincide
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			credits <= bus_pkg::CREDIT_WIDTH'(bus_pkg::QUEUE_DEPTH);
		else if (o_cmd_push && !i_credit_return)
			credits <= credits - 1'b1;
		else if (!o_cmd_push && i_credit_return)
			credits <= credits + 1'b1;
	end

	//======================================================================
	// Sequencer

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= bus_pkg::MASTER_IDLE;
			src_ptr <= '0;
			dst_ptr <= '0;
			remaining <= '0;
		end
		else
		begin
			case (state)
				bus_pkg::MASTER_IDLE:
				begin
					if (dma_start)
					begin
						src_ptr <= dma_source;
						dst_ptr <= dma_dest;
						remaining <= dma_count;
						state <= bus_pkg::DMA_ISSUE_READ;
					end
					else if (host_issue && !i_host_rw)
						state <= bus_pkg::MASTER_HOST_READ;
				end
				bus_pkg::MASTER_HOST_READ:
				begin
					if (i_rsp_valid)
						state <= bus_pkg::MASTER_IDLE;
				end
				bus_pkg::DMA_ISSUE_READ:
				begin
					if (has_credit)
					begin
						src_ptr <= src_ptr + 4;
						state <= bus_pkg::DMA_WAIT_READ;
					end
				end
				bus_pkg::DMA_WAIT_READ:
				begin
					if (i_rsp_valid)
						state <= bus_pkg::DMA_ISSUE_WRITE;
				end
				bus_pkg::DMA_ISSUE_WRITE:
				begin
					if (has_credit)
					begin
						dst_ptr <= dst_ptr + 4;
						remaining <= remaining - 1'b1;
						// Last word written
						if (remaining == 1)
							state <= bus_pkg::MASTER_IDLE;
						else
							state <= bus_pkg::DMA_ISSUE_READ;
					end
				end
				default:
					state <= bus_pkg::MASTER_IDLE;
			endcase
		end
	end

	// Word in flight between read and write
	always_ff @(posedge clock)
	begin
		if (state == bus_pkg::DMA_WAIT_READ && i_rsp_valid)
			dma_data <= i_rsp_rdata;
	end

endmodule

// File: source/command_queue.sv
`timescale 1ns/10ps

module command_queue (
	input  logic                            clock,
	input  logic                            i_rst_n,

	// Write side
	input  logic                            i_push,
	input  bus_pkg::cmd_op_t                i_op,
	input  logic [bus_pkg::ADDR_WIDTH-1:0]  i_address,
	input  logic [bus_pkg::DATA_WIDTH-1:0]  i_wdata,

	// Read side
	input  logic                            i_pop,
	output logic                            o_valid,
	output bus_pkg::cmd_op_t                o_op,
	output logic [bus_pkg::ADDR_WIDTH-1:0]  o_address,
	output logic [bus_pkg::DATA_WIDTH-1:0]  o_wdata,

	output logic                            o_credit_return
);

	// Entry storage
	bus_pkg::cmd_op_t op_mem [bus_pkg::QUEUE_DEPTH];
	logic [bus_pkg::ADDR_WIDTH-1:0] address_mem [bus_pkg::QUEUE_DEPTH];
	logic [bus_pkg::DATA_WIDTH-1:0] wdata_mem [bus_pkg::QUEUE_DEPTH];

	// One extra wrap bit tells full from empty
	logic [bus_pkg::QUEUE_ADDR_WIDTH:0] wr_ptr;
	logic [bus_pkg::QUEUE_ADDR_WIDTH:0] rd_ptr;
	logic do_pop;

	assign o_valid = wr_ptr != rd_ptr;
	assign do_pop = i_pop && o_valid;

	assign o_op = op_mem[rd_ptr[bus_pkg::QUEUE_ADDR_WIDTH-1:0]];
	assign o_address = address_mem[rd_ptr[bus_pkg::QUEUE_ADDR_WIDTH-1:0]];
	assign o_wdata = wdata_mem[rd_ptr[bus_pkg::QUEUE_ADDR_WIDTH-1:0]];

	always_ff @(posedge clock)
	begin
		if (i_push)
		begin
			op_mem[wr_ptr[bus_pkg::QUEUE_ADDR_WIDTH-1:0]] <= i_op;
			address_mem[wr_ptr[bus_pkg::QUEUE_ADDR_WIDTH-1:0]] <= i_address;
			wdata_mem[wr_ptr[bus_pkg::QUEUE_ADDR_WIDTH-1:0]] <= i_wdata;
		end
	end

	// Pointers and credit pulse
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_credit_return <= 1'b0;
		end
		else
		begin
			if (i_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			o_credit_return <= do_pop;
		end
	end

endmodule

// File: source/target_port.sv
`timescale 1ns/10ps

module target_port (
	input  logic                            clock,
	input  logic                            i_rst_n,

	// Queue head
	input  logic                            i_valid,
	input  bus_pkg::cmd_op_t                i_op,
	input  logic [bus_pkg::ADDR_WIDTH-1:0]  i_address,
	input  logic [bus_pkg::DATA_WIDTH-1:0]  i_wdata,
	output logic                            o_pop,

	// Read response back to the master
	output logic                            o_rsp_valid,
	output logic [bus_pkg::DATA_WIDTH-1:0]  o_rsp_rdata,

	output logic [bus_pkg::LED_WIDTH-1:0]   o_led
);

	bus_pkg::region_t region;
	logic [bus_pkg::RAM_INDEX_WIDTH-1:0] ram_index;
	logic do_write;
	logic do_read;

	logic [bus_pkg::DATA_WIDTH-1:0] ram [bus_pkg::RAM_WORDS];
	logic [bus_pkg::LED_WIDTH-1:0] led_q;

	//======================================================================
	// Decode

	assign region = bus_pkg::region_t'(i_address[31:28]);
	assign ram_index = i_address[bus_pkg::RAM_INDEX_WIDTH+1:2];

	// No pop while a read response goes out
	assign o_pop = i_valid && !o_rsp_valid;
	assign do_write = o_pop && i_op == bus_pkg::CMD_WRITE;
	assign do_read = o_pop && i_op == bus_pkg::CMD_READ;

	assign o_led = led_q;

	//======================================================================
	// RAM target

	always_ff @(posedge clock)
	begin
		if (do_write && region == bus_pkg::REGION_RAM)
			ram[ram_index] <= i_wdata;
	end

	//======================================================================
	// LED target

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			led_q <= '0;
		else if (do_write && region == bus_pkg::REGION_LED)
			led_q <= i_wdata[bus_pkg::LED_WIDTH-1:0];
	end

	//======================================================================
	// Read response

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_rsp_valid <= 1'b0;
		else
			o_rsp_valid <= do_read;
	end

	// Unmapped regions read as zero
	always_ff @(posedge clock)
	begin
		if (do_read)
		begin
			case (region)
				bus_pkg::REGION_RAM:
					o_rsp_rdata <= ram[ram_index];
				bus_pkg::REGION_LED:
					o_rsp_rdata <= {{(bus_pkg::DATA_WIDTH-bus_pkg::LED_WIDTH){1'b0}}, led_q};
				default:
					o_rsp_rdata <= '0;
			endcase
		end
	end

endmodule

// File: source/soc_bus_top.sv
`timescale 1ns/10ps

module soc_bus_top (
	input  logic                            clock,
	input  logic                            i_rst_n,

	input  logic                            i_host_request,
	input  logic                            i_host_rw,
	input  logic [bus_pkg::ADDR_WIDTH-1:0]  i_host_address,
	input  logic [bus_pkg::DATA_WIDTH-1:0]  i_host_wdata,
	output logic [bus_pkg::DATA_WIDTH-1:0]  o_host_rdata,
	output logic                            o_host_ready,

	output logic [bus_pkg::LED_WIDTH-1:0]   o_led,
	output logic                            o_dma_busy
);

	//======================================================================
	// Command path

	logic cmd_push;
	bus_pkg::cmd_op_t cmd_op;
	logic [bus_pkg::ADDR_WIDTH-1:0] cmd_address;
	logic [bus_pkg::DATA_WIDTH-1:0] cmd_wdata;
	logic credit_return;

	// Queue head
	logic q_valid;
	logic q_pop;
	bus_pkg::cmd_op_t q_op;
	logic [bus_pkg::ADDR_WIDTH-1:0] q_address;
	logic [bus_pkg::DATA_WIDTH-1:0] q_wdata;

	// Response path
	logic rsp_valid;
	logic [bus_pkg::DATA_WIDTH-1:0] rsp_rdata;

	bus_master bus_master_i (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_host_request(i_host_request),
		.i_host_rw(i_host_rw),
		.i_host_address(i_host_address),
		.i_host_wdata(i_host_wdata),
		.o_host_rdata(o_host_rdata),
		.o_host_ready(o_host_ready),
		.i_credit_return(credit_return),
		.o_cmd_push(cmd_push),
		.o_cmd_op(cmd_op),
		.o_cmd_address(cmd_address),
		.o_cmd_wdata(cmd_wdata),
		.i_rsp_valid(rsp_valid),
		.i_rsp_rdata(rsp_rdata),
		.o_dma_busy(o_dma_busy)
	);

	command_queue command_queue_i (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_push(cmd_push),
		.i_op(cmd_op),
		.i_address(cmd_address),
		.i_wdata(cmd_wdata),
		.i_pop(q_pop),
		.o_valid(q_valid),
		.o_op(q_op),
		.o_address(q_address),
		.o_wdata(q_wdata),
		.o_credit_return(credit_return)
	);

	target_port target_port_i (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_valid(q_valid),
		.i_op(q_op),
		.i_address(q_address),
		.i_wdata(q_wdata),
		.o_pop(q_pop),
		.o_rsp_valid(rsp_valid),
		.o_rsp_rdata(rsp_rdata),
		.o_led(o_led)
	);

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
	output logic clock,
	output logic o_rst_n
);

	localparam real HALF_PERIOD = 10.0;
	localparam int RESET_CYCLES = 10;

	initial
	begin
		clock = 1'b0;
		forever
			#HALF_PERIOD clock = ~clock;
	end

	// Release lines up with the stimulus delay
	initial
	begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clock);
		#2;
		o_rst_n = 1'b1;
	end

endmodule

// File: bench/soc_bus_tb.sv
`timescale 1ns/10ps

module soc_bus_tb;

	localparam int DRIVE_DELAY = 2;
	localparam int RAM_WRITES = 64;
	localparam int BURSTS = 4;
	localparam int BURST_WRITES = 20;
	localparam int BURST_READS = 10;
	localparam int MAX_COUNT = 16;
	localparam int MAX_POLLS = 100;
	// Host accesses per test, summed over all tests
	localparam int NUM_TRANSACTIONS = 2 * RAM_WRITES + 5 + (2 * MAX_COUNT + 7 + MAX_POLLS)
		+ BURSTS * (BURST_WRITES + BURST_READS);
	localparam int TIMEOUT_NS = NUM_TRANSACTIONS * 200 + 20000;

	logic clock;
	logic rst_n;
	logic host_request;
	logic host_rw;
	logic [31:0] host_address;
	logic [31:0] host_wdata;
	logic [31:0] o_host_rdata;
	logic o_host_ready;
	logic [bus_pkg::LED_WIDTH-1:0] o_led;
	logic o_dma_busy;

	// Reference model
	logic [31:0] ram_model [bus_pkg::RAM_WORDS];
	logic [bus_pkg::LED_WIDTH-1:0] led_model;
	int written[$];

	int error_count;
	int pass_count;
	int errors_before;

	clock_gen clock_gen_i (
		.clock(clock),
		.o_rst_n(rst_n)
	);

	soc_bus_top soc_bus_top_i (
		.clock(clock),
		.i_rst_n(rst_n),
		.i_host_request(host_request),
		.i_host_rw(host_rw),
		.i_host_address(host_address),
		.i_host_wdata(host_wdata),
		.o_host_rdata(o_host_rdata),
		.o_host_ready(o_host_ready),
		.o_led(o_led),
		.o_dma_busy(o_dma_busy)
	);

	//======================================================================
	// Helpers

	function automatic logic [31:0] ram_address(input int index, input logic [17:0] upper);
		return {4'(bus_pkg::REGION_RAM), upper, index[7:0], 2'b00};
	endfunction

	function automatic logic [31:0] dma_address(input logic [1:0] index);
		return {4'(bus_pkg::REGION_DMA), 24'h0, index, 2'b00};
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			error_count++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
		else
			pass_count++;
	endtask

	// Holds the request until ready is seen before a rising edge
	task automatic bus_access(input logic rw, input logic [31:0] address,
		input logic [31:0] wdata, output logic [31:0] rdata);
		host_request = 1'b1;
		host_rw = rw;
		host_address = address;
		host_wdata = wdata;
		@(negedge clock);
		while (!o_host_ready)
			@(negedge clock);
		rdata = o_host_rdata;
		@(posedge clock);
		#DRIVE_DELAY;
		host_request = 1'b0;
	endtask

	task automatic report_test(input string name);
		$display("Test %s finished with %0d errors", name, error_count - errors_before);
		errors_before = error_count;
	endtask

	//======================================================================
	// Watchdog

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("*** FAILED ***");
		$finish;
	end

	//======================================================================
	// Stimulus

	initial
	begin
		int seed_value;
		int idx;
		int count;
		int src_idx;
		int dst_idx;
		int polls;
		logic [31:0] data;
		logic [31:0] rdata;
		logic [31:0] unmapped_address;

		seed_value = $urandom(32'h94425cf5);
		host_request = 1'b0;
		host_rw = 1'b0;
		host_address = '0;
		host_wdata = '0;
		led_model = '0;
		error_count = 0;
		pass_count = 0;
		errors_before = 0;

		@(posedge rst_n);
		@(negedge clock);
		compare_value("o_led", 32'h0, 32'(o_led));
		compare_value("o_dma_busy", 32'h0, 32'(o_dma_busy));
		compare_value("o_host_ready", 32'h0, 32'(o_host_ready));
		@(posedge clock);
		#DRIVE_DELAY;
		report_test("reset_values");

		// Random RAM writes, then read every written word back
		for (int i = 0; i < RAM_WRITES; i++)
		begin
			idx = $urandom % bus_pkg::RAM_WORDS;
			data = $urandom;
			bus_access(1'b1, ram_address(idx, 18'($urandom)), data, rdata);
			ram_model[idx] = data;
			written.push_back(idx);
		end
		foreach (written[i])
		begin
			bus_access(1'b0, ram_address(written[i], 18'($urandom)), '0, rdata);
			compare_value("o_host_rdata", ram_model[written[i]], rdata);
		end
		report_test("ram_random_access");

		data = $urandom;
		bus_access(1'b1, 32'h4000_0000, data, rdata);
		led_model = data[bus_pkg::LED_WIDTH-1:0];
		bus_access(1'b0, 32'h4000_0000, '0, rdata);
		compare_value("o_host_rdata", 32'(led_model), rdata);
		compare_value("o_led", 32'(led_model), 32'(o_led));
		// Region 0x7 has no target, same word index as a written RAM word
		unmapped_address = ram_address(written[0], 18'h0);
		unmapped_address[31:28] = 4'h7;
		bus_access(1'b1, unmapped_address, $urandom, rdata);
		bus_access(1'b0, unmapped_address, '0, rdata);
		compare_value("o_host_rdata", 32'h0, rdata);
		compare_value("o_led", 32'(led_model), 32'(o_led));
		bus_access(1'b0, ram_address(written[0], 18'h0), '0, rdata);
		compare_value("o_host_rdata", ram_model[written[0]], rdata);
		report_test("led_and_unmapped");

		//==================================================================
		// DMA copy between two disjoint RAM ranges

		count = 1 + $urandom % MAX_COUNT;
		src_idx = $urandom % 64;
		dst_idx = 128 + $urandom % 64;
		for (int i = 0; i < count; i++)
		begin
			data = $urandom;
			bus_access(1'b1, ram_address(src_idx + i, 18'h0), data, rdata);
			ram_model[src_idx + i] = data;
		end
		bus_access(1'b1, dma_address(bus_pkg::DMA_REG_SOURCE), ram_address(src_idx, 18'h0), rdata);
		bus_access(1'b1, dma_address(bus_pkg::DMA_REG_DEST), ram_address(dst_idx, 18'h0), rdata);
		bus_access(1'b1, dma_address(bus_pkg::DMA_REG_COUNT), 32'(count), rdata);
		bus_access(1'b0, dma_address(bus_pkg::DMA_REG_SOURCE), '0, rdata);
		compare_value("o_host_rdata", ram_address(src_idx, 18'h0), rdata);
		bus_access(1'b0, dma_address(bus_pkg::DMA_REG_DEST), '0, rdata);
		compare_value("o_host_rdata", ram_address(dst_idx, 18'h0), rdata);
		bus_access(1'b0, dma_address(bus_pkg::DMA_REG_COUNT), '0, rdata);
		compare_value("o_host_rdata", 32'(count), rdata);

		bus_access(1'b1, dma_address(bus_pkg::DMA_REG_CONTROL), 32'h1, rdata);
		compare_value("o_dma_busy", 32'h1, 32'(o_dma_busy));
		for (int i = 0; i < count; i++)
		begin
			ram_model[dst_idx + i] = ram_model[src_idx + i];
			written.push_back(dst_idx + i);
		end
		polls = 0;
		do
		begin
			bus_access(1'b0, dma_address(bus_pkg::DMA_REG_CONTROL), '0, rdata);
			polls++;
		end
		while (rdata[0] && polls < MAX_POLLS);
		if (rdata[0])
		begin
			error_count++;
			$display("DMA copy still busy after %0d polls of CONTROL", polls);
		end
		compare_value("o_dma_busy", 32'h0, 32'(o_dma_busy));
		for (int i = 0; i < count; i++)
		begin
			bus_access(1'b0, ram_address(dst_idx + i, 18'h0), '0, rdata);
			compare_value("o_host_rdata", ram_model[dst_idx + i], rdata);
		end
		report_test("dma_copy");

		// Back-to-back write bursts keep the queue full
		for (int b = 0; b < BURSTS; b++)
		begin
			for (int i = 0; i < BURST_WRITES; i++)
			begin
				idx = $urandom % bus_pkg::RAM_WORDS;
				data = $urandom;
				bus_access(1'b1, ram_address(idx, 18'h0), data, rdata);
				ram_model[idx] = data;
				written.push_back(idx);
			end
			for (int i = 0; i < BURST_READS; i++)
			begin
				idx = written[$urandom % written.size()];
				bus_access(1'b0, ram_address(idx, 18'h0), '0, rdata);
				compare_value("o_host_rdata", ram_model[idx], rdata);
			end
		end
		report_test("credit_stress");

		$display("Checks passed: %0d, errors: %0d", pass_count, error_count);
		if (error_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: project.f
source/bus_pkg.sv
source/bus_master.sv
source/command_queue.sv
source/target_port.sv
source/soc_bus_top.sv
bench/clock_gen.sv
bench/soc_bus_tb.sv
